// ==== src/stream_pkg.sv ====
// Stream scaler shared types for samples, gain, output words and register map
`default_nettype none

package stream_pkg;

  // Signed stream sample
  typedef logic signed [15:0] sample_t;

  // Unsigned Q4.4 gain, 16 is unity
  typedef logic [7:0] gain_t;

  // Output FIFO payload
  typedef struct packed {
    logic    sat;     // Result was clipped
    sample_t sample;
  } out_word_t;

  typedef logic [1:0]  reg_addr_t;
  typedef logic [15:0] reg_data_t;

  // Register map
  localparam reg_addr_t ADDR_GAIN   = 2'd0;
  localparam reg_addr_t ADDR_OFFSET = 2'd1;
  localparam reg_addr_t ADDR_CTRL   = 2'd2;
  localparam reg_addr_t ADDR_SATCNT = 2'd3;

  localparam gain_t GainReset = 8'd16;  // Unity

endpackage

`default_nettype wire

// ==== src/fifo.sv ====
// Fall-through FIFO with valid/ready handshake on both sides and a generic payload type
`default_nettype none

module fifo #(
  parameter type data_t = logic [15:0],  // Payload type
  parameter int  Depth  = 8              // Number of stored entries
) (
  input  logic  clk_i,
  input  logic  arst_ni,

  // Write side
  input  data_t data_in_i,
  input  logic  data_in_valid_i,
  output logic  data_in_ready_o,

  // Read side
  output data_t data_out_o,
  output logic  data_out_valid_o,
  input  logic  data_out_ready_i
);

  localparam int PtrW = $clog2(Depth) + 1;

  data_t fifo_mem [Depth];

  logic [PtrW-1:0] wr_ptr;
  logic [PtrW-1:0] rd_ptr;
  logic [PtrW-1:0] wr_ptr_next;
  logic [PtrW-1:0] rd_ptr_next;
  logic [PtrW-1:0] str_count;  // Entries currently held

  logic data_in_hs;
  logic data_out_hs;

  assign data_in_hs  = data_in_valid_i && data_in_ready_o;
  assign data_out_hs = data_out_valid_o && data_out_ready_i;

  // When full, a pop in the same cycle frees a slot
  assign data_in_ready_o  = (str_count == PtrW'(Depth)) ? data_out_ready_i : 1'b1;
  // Empty buffer passes the input straight through
  assign data_out_valid_o = (str_count == '0) ? data_in_valid_i : 1'b1;
  assign data_out_o       = (str_count != '0) ? fifo_mem[rd_ptr[PtrW-2:0]] : data_in_i;

  // Pointers wrap at Depth
  assign wr_ptr_next = ((wr_ptr + 1'b1) == PtrW'(Depth)) ? '0 : wr_ptr + 1'b1;
  assign rd_ptr_next = ((rd_ptr + 1'b1) == PtrW'(Depth)) ? '0 : rd_ptr + 1'b1;

  always_ff @(posedge clk_i or negedge arst_ni) begin
    if (!arst_ni) begin
      str_count <= '0;
      wr_ptr    <= '0;
      rd_ptr    <= '0;
    end else begin
      case ({data_in_hs, data_out_hs})
        2'b11: begin  // Push and pop, count holds
          wr_ptr <= wr_ptr_next;
          rd_ptr <= rd_ptr_next;
        end
        2'b10: begin
          wr_ptr    <= wr_ptr_next;
          str_count <= str_count + 1'b1;
        end
        2'b01: begin
          rd_ptr    <= rd_ptr_next;
          str_count <= str_count - 1'b1;
        end
        default: ;  // Idle
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (data_in_hs) begin
      fifo_mem[wr_ptr[PtrW-2:0]] <= data_in_i;
    end
  end

endmodule

`default_nettype wire

// ==== src/gain_stage.sv ====
// Gain stage that multiplies by a Q4.4 gain, adds an offset and saturates, one register deep
`default_nettype none

module gain_stage (
  input  logic                 clk_i,
  input  logic                 arst_ni,
  input  stream_pkg::sample_t  in_data_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  output stream_pkg::out_word_t out_data_o,
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  input  stream_pkg::gain_t    gain_i,
  input  stream_pkg::sample_t  offset_i,
  input  logic                 enable_i,
  output logic                 sat_o
);

  localparam int SumW = 26;  // Room for 16x9 product plus offset
  localparam logic signed [SumW-1:0] SatMax = 32767;
  localparam logic signed [SumW-1:0] SatMin = -32768;

  logic signed [8:0]      gain_ext;
  logic signed [24:0]     product;
  logic signed [SumW-1:0] sum;
  logic                   sat_hi;
  logic                   sat_lo;
  stream_pkg::out_word_t  result;

  logic                   out_valid_q;
  stream_pkg::out_word_t  out_data_q;
  logic                   in_hs;
  logic                   out_hs;

  assign gain_ext = {1'b0, gain_i};  // Gain is unsigned
  assign product  = in_data_i * gain_ext;
  // Drop the four fraction bits, truncating toward minus infinity
  assign sum      = (product >>> 4) + offset_i;

  assign sat_hi = sum > SatMax;
  assign sat_lo = sum < SatMin;

  always_comb begin
    result.sat = sat_hi || sat_lo;
    if (sat_hi) begin
      result.sample = 16'sh7fff;
    end else if (sat_lo) begin
      result.sample = 16'sh8000;
    end else begin
      result.sample = sum[15:0];
    end
  end

  // Register drains even while disabled
  assign in_ready_o = enable_i && (!out_valid_q || out_ready_i);
  assign in_hs      = in_valid_i && in_ready_o;
  assign out_hs     = out_valid_q && out_ready_i;

  always_ff @(posedge clk_i or negedge arst_ni) begin
    if (!arst_ni) begin
      out_valid_q <= 1'b0;
    end else if (in_hs) begin
      out_valid_q <= 1'b1;
    end else if (out_hs) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_hs) begin
      out_data_q <= result;
    end
  end

  assign out_data_o  = out_data_q;
  assign out_valid_o = out_valid_q;
  assign sat_o       = in_hs && result.sat;  // Strobe on load of a clipped word

endmodule

`default_nettype wire

// ==== src/scaler_regs.sv ====
// Scaler register bank on a four-phase req/ack bus with gain, offset, enable and a clip counter
`default_nettype none

module scaler_regs (
  input  logic                  clk_i,
  input  logic                  arst_ni,
  input  logic                  reg_req_i,
  input  logic                  reg_we_i,
  input  stream_pkg::reg_addr_t reg_addr_i,
  input  stream_pkg::reg_data_t reg_wdata_i,
  output logic                  reg_ack_o,
  output stream_pkg::reg_data_t reg_rdata_o,
  input  logic                  sat_i,
  output stream_pkg::gain_t     gain_o,
  output stream_pkg::sample_t   offset_o,
  output logic                  enable_o
);

  typedef enum logic {
    ST_IDLE,
    ST_ACK
  } state_e;

  state_e                state_q;
  logic                  access;  // Request seen while idle
  logic                  sat_clr;
  stream_pkg::reg_data_t read_mux;
  stream_pkg::reg_data_t rdata_q;

  stream_pkg::gain_t     gain_q;
  stream_pkg::sample_t   offset_q;
  logic                  enable_q;
  logic [15:0]           sat_cnt_q;

  assign access  = (state_q == ST_IDLE) && reg_req_i;
  assign sat_clr = access && reg_we_i && (reg_addr_i == stream_pkg::ADDR_SATCNT);

  // Handshake FSM, ack holds until req falls
  always_ff @(posedge clk_i or negedge arst_ni) begin
    if (!arst_ni) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: if (reg_req_i) state_q <= ST_ACK;
        ST_ACK:  if (!reg_req_i) state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Configuration writes
  always_ff @(posedge clk_i or negedge arst_ni) begin
    if (!arst_ni) begin
      gain_q   <= stream_pkg::GainReset;
      offset_q <= '0;
      enable_q <= 1'b0;
    end else if (access && reg_we_i) begin
      case (reg_addr_i)
        stream_pkg::ADDR_GAIN:   gain_q   <= reg_wdata_i[7:0];
        stream_pkg::ADDR_OFFSET: offset_q <= reg_wdata_i;
        stream_pkg::ADDR_CTRL:   enable_q <= reg_wdata_i[0];
        default: ;  // Counter clear handled below
      endcase
    end
  end

  // Saturating clip counter, clear has priority
  always_ff @(posedge clk_i or negedge arst_ni) begin
    if (!arst_ni) begin
      sat_cnt_q <= '0;
    end else if (sat_clr) begin
      sat_cnt_q <= '0;
    end else if (sat_i && (sat_cnt_q != 16'hffff)) begin
      sat_cnt_q <= sat_cnt_q + 1'b1;
    end
  end

  always_comb begin
    case (reg_addr_i)
      stream_pkg::ADDR_GAIN:   read_mux = {8'h00, gain_q};
      stream_pkg::ADDR_OFFSET: read_mux = offset_q;
      stream_pkg::ADDR_CTRL:   read_mux = {15'h0000, enable_q};
      default:                 read_mux = sat_cnt_q;
    endcase
  end

  // Read data captured with the rising ack
  always_ff @(posedge clk_i) begin
    if (access) begin
      rdata_q <= read_mux;
    end
  end

  assign reg_ack_o   = (state_q == ST_ACK);
  assign reg_rdata_o = rdata_q;
  assign gain_o      = gain_q;
  assign offset_o    = offset_q;
  assign enable_o    = enable_q;

endmodule

`default_nettype wire

// ==== src/stream_scaler_top.sv ====
// Sample stream scaler with input FIFO, gain stage, output FIFO and register bank
`default_nettype none

module stream_scaler_top #(
  parameter int InDepth  = 4,
  parameter int OutDepth = 4
) (
  input  logic                  clk_i,
  input  logic                  arst_ni,

  // Sample input stream
  input  stream_pkg::sample_t   s_data_i,
  input  logic                  s_valid_i,
  output logic                  s_ready_o,

  // Scaled output stream
  output stream_pkg::sample_t   m_data_o,
  output logic                  m_sat_o,
  output logic                  m_valid_o,
  input  logic                  m_ready_i,

  // Register bus
  input  logic                  reg_req_i,
  input  logic                  reg_we_i,
  input  stream_pkg::reg_addr_t reg_addr_i,
  input  stream_pkg::reg_data_t reg_wdata_i,
  output logic                  reg_ack_o,
  output stream_pkg::reg_data_t reg_rdata_o
);

  stream_pkg::sample_t   in_fifo_data;
  logic                  in_fifo_valid;
  logic                  gs_in_ready;
  stream_pkg::out_word_t gs_data;
  logic                  gs_valid;
  logic                  out_fifo_ready;
  stream_pkg::out_word_t out_word;

  stream_pkg::gain_t     gain;
  stream_pkg::sample_t   offset;
  logic                  enable;
  logic                  sat_pulse;

  fifo #(
    .data_t (stream_pkg::sample_t),
    .Depth  (InDepth)
  ) u_in_fifo (
    .clk_i            (clk_i),
    .arst_ni          (arst_ni),
    .data_in_i        (s_data_i),
    .data_in_valid_i  (s_valid_i),
    .data_in_ready_o  (s_ready_o),
    .data_out_o       (in_fifo_data),
    .data_out_valid_o (in_fifo_valid),
    .data_out_ready_i (gs_in_ready)
  );

  gain_stage u_gain_stage (
    .clk_i       (clk_i),
    .arst_ni     (arst_ni),
    .in_data_i   (in_fifo_data),
    .in_valid_i  (in_fifo_valid),
    .in_ready_o  (gs_in_ready),
    .out_data_o  (gs_data),
    .out_valid_o (gs_valid),
    .out_ready_i (out_fifo_ready),
    .gain_i      (gain),
    .offset_i    (offset),
    .enable_i    (enable),
    .sat_o       (sat_pulse)
  );

  fifo #(
    .data_t (stream_pkg::out_word_t),
    .Depth  (OutDepth)
  ) u_out_fifo (
    .clk_i            (clk_i),
    .arst_ni          (arst_ni),
    .data_in_i        (gs_data),
    .data_in_valid_i  (gs_valid),
    .data_in_ready_o  (out_fifo_ready),
    .data_out_o       (out_word),
    .data_out_valid_o (m_valid_o),
    .data_out_ready_i (m_ready_i)
  );

  scaler_regs u_regs (
    .clk_i       (clk_i),
    .arst_ni     (arst_ni),
    .reg_req_i   (reg_req_i),
    .reg_we_i    (reg_we_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_ack_o   (reg_ack_o),
    .reg_rdata_o (reg_rdata_o),
    .sat_i       (sat_pulse),
    .gain_o      (gain),
    .offset_o    (offset),
    .enable_o    (enable)
  );

  assign m_data_o = out_word.sample;
  assign m_sat_o  = out_word.sat;  // Clip flag travels with its sample

endmodule

`default_nettype wire

// ==== bench/stream_scaler_chk.sv ====
// Stream scaler protocol checks on output stall stability, register bus order and reset state
`default_nettype none

module stream_scaler_chk (
  input logic                clk_i,
  input logic                arst_ni,
  input stream_pkg::sample_t m_data_o,
  input logic                m_sat_o,
  input logic                m_valid_o,
  input logic                m_ready_i,
  input logic                reg_req_i,
  input logic                reg_ack_o
);

  int fail_cnt = 0;  // Read by the testbench at the end

  // Output word holds while the sink stalls
  stall_stable: assert property (@(posedge clk_i) disable iff (!arst_ni)
    m_valid_o && !m_ready_i |=> m_valid_o && $stable(m_data_o) && $stable(m_sat_o))
    else begin
      fail_cnt++;
      $error("Output stream changed while stalled");
    end

  ack_needs_req: assert property (@(posedge clk_i) disable iff (!arst_ni)
    $rose(reg_ack_o) |-> $past(reg_req_i))
    else begin
      fail_cnt++;
      $error("Register ack rose without a request");
    end

  // Master may drop req only once ack is seen
  req_held: assert property (@(posedge clk_i) disable iff (!arst_ni)
    $fell(reg_req_i) |-> reg_ack_o)
    else begin
      fail_cnt++;
      $error("Register request fell before ack");
    end

  reset_quiet: assert property (@(posedge clk_i) !arst_ni |-> !m_valid_o && !reg_ack_o)
    else begin
      fail_cnt++;
      $error("Valid or ack high during reset");
    end

endmodule

bind stream_scaler_top stream_scaler_chk u_chk (.*);

`default_nettype wire

// ==== bench/tb_stream_scaler.sv ====
// Stream scaler testbench with register accesses, random streams and an in-order scoreboard
`default_nettype none

module tb_stream_scaler;

  localparam int InDepth  = 4;
  localparam int OutDepth = 4;
  localparam int WaitMax  = 400;  // Cycles before any wait gives up

  logic                  clk;
  logic                  arst_n;
  stream_pkg::sample_t   s_data;
  logic                  s_valid;
  logic                  s_ready;
  stream_pkg::sample_t   m_data;
  logic                  m_sat;
  logic                  m_valid;
  logic                  m_ready;
  logic                  reg_req;
  logic                  reg_we;
  stream_pkg::reg_addr_t reg_addr;
  stream_pkg::reg_data_t reg_wdata;
  logic                  reg_ack;
  stream_pkg::reg_data_t reg_rdata;

  logic [16:0]         exp_q[$];  // Expected {sat, sample} in input order
  logic [31:0]         rnd_state;
  logic                rand_ready;
  logic                hold_ready;
  stream_pkg::gain_t   cfg_gain;
  stream_pkg::sample_t cfg_offset;
  int                  acc_cnt;
  int                  out_cnt;
  int                  sat_exp;
  int                  mismatch_errs;
  int                  other_errs;

  stream_scaler_top #(
    .InDepth  (InDepth),
    .OutDepth (OutDepth)
  ) dut (
    .clk_i       (clk),
    .arst_ni     (arst_n),
    .s_data_i    (s_data),
    .s_valid_i   (s_valid),
    .s_ready_o   (s_ready),
    .m_data_o    (m_data),
    .m_sat_o     (m_sat),
    .m_valid_o   (m_valid),
    .m_ready_i   (m_ready),
    .reg_req_i   (reg_req),
    .reg_we_i    (reg_we),
    .reg_addr_i  (reg_addr),
    .reg_wdata_i (reg_wdata),
    .reg_ack_o   (reg_ack),
    .reg_rdata_o (reg_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] x);
    return x * 32'd1664525 + 32'd1013904223;
  endfunction

  // Scaling rule: x * gain / 16 with floor, plus offset, clipped to 16 bits
  function automatic logic [16:0] scale_ref(input stream_pkg::sample_t x,
                                            input stream_pkg::gain_t g,
                                            input stream_pkg::sample_t off);
    int gi;
    int sum;
    gi  = {24'h000000, g};
    sum = ((int'(x) * gi) >>> 4) + int'(off);
    if (sum > 32767) return {1'b1, 16'h7fff};
    if (sum < -32768) return {1'b1, 16'h8000};
    return {1'b0, sum[15:0]};
  endfunction

  // Full range, or large magnitudes near either rail
  function automatic stream_pkg::sample_t next_sample(input bit big);
    rnd_state = lcg_next(rnd_state);
    if (!big) return rnd_state[31:16];
    if (rnd_state[31]) return 16'sh8000 + 16'(rnd_state[12:0]);
    return 16'sh7fff - 16'(rnd_state[12:0]);
  endfunction

  // Sink ready, random or held
  initial begin
    logic [31:0] rdy_state;
    rdy_state = lcg_next(32'h8873_a493);
    m_ready   = 1'b0;
    forever begin
      @(negedge clk);
      rdy_state = lcg_next(rdy_state);
      m_ready   = rand_ready ? (rdy_state[29] | rdy_state[30]) : hold_ready;
    end
  end

  // Scoreboard, model word computed when the sample enters
  always @(posedge clk) begin
    logic [16:0] w;
    if (arst_n) begin
      if (s_valid && s_ready) begin
        w = scale_ref(s_data, cfg_gain, cfg_offset);
        exp_q.push_back(w);
        sat_exp += int'(w[16]);
        acc_cnt++;
      end
      if (m_valid && m_ready) begin
        if (exp_q.size() == 0) begin
          other_errs++;
          $display("Output transfer at %0t with no sample pending", $time);
        end else begin
          w = exp_q.pop_front();
          if ({m_sat, m_data} !== w) begin
            mismatch_errs++;
            $display("MISMATCH at %0t: output %0d got sat=%0b data=%0d, expected sat=%0b data=%0d",
                     $time, out_cnt, m_sat, m_data, w[16], $signed(w[15:0]));
          end
        end
        out_cnt++;
      end
    end
  end

  task automatic wait_accept(input int target);
    int n;
    n = 0;
    while (acc_cnt < target && n < WaitMax) begin
      @(negedge clk);
      n++;
    end
    if (acc_cnt < target) begin
      other_errs++;
      $display("Input sample was not accepted in time at %0t", $time);
    end
  endtask

  task automatic send(input int count, input bit big);
    for (int i = 0; i < count; i++) begin
      s_data  = next_sample(big);
      s_valid = 1'b1;
      wait_accept(acc_cnt + 1);
    end
    s_valid = 1'b0;
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < WaitMax) begin
      @(negedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      other_errs++;
      $display("Output stream did not drain, %0d samples missing", exp_q.size());
    end
  endtask

  // One four-phase access, ends on a falling edge with req and ack low
  task automatic reg_xfer(input logic we, input stream_pkg::reg_addr_t addr,
                          input stream_pkg::reg_data_t wdata,
                          output stream_pkg::reg_data_t rdata);
    int n;
    reg_we    = we;
    reg_addr  = addr;
    reg_wdata = wdata;
    reg_req   = 1'b1;
    n = 0;
    while (!reg_ack && n < WaitMax) begin
      @(negedge clk);
      n++;
    end
    if (!reg_ack) begin
      other_errs++;
      $display("Register bus gave no ack at %0t", $time);
    end
    rdata   = reg_rdata;
    reg_req = 1'b0;
    n = 0;
    while (reg_ack && n < WaitMax) begin
      @(negedge clk);
      n++;
    end
    if (reg_ack) begin
      other_errs++;
      $display("Register ack stayed high after the request fell at %0t", $time);
    end
  endtask

  task automatic reg_write(input stream_pkg::reg_addr_t addr, input stream_pkg::reg_data_t data);
    stream_pkg::reg_data_t unused;
    reg_xfer(1'b1, addr, data, unused);
    if (addr == stream_pkg::ADDR_GAIN) cfg_gain = data[7:0];
    if (addr == stream_pkg::ADDR_OFFSET) cfg_offset = data;
  endtask

  task automatic reg_check(input stream_pkg::reg_addr_t addr, input stream_pkg::reg_data_t exp);
    stream_pkg::reg_data_t got;
    reg_xfer(1'b0, addr, 16'h0000, got);
    if (got !== exp) begin
      mismatch_errs++;
      $display("MISMATCH at %0t: register %0d read %h, expected %h", $time, addr, got, exp);
    end
  endtask

  initial begin
    int base;
    int last;
    int out_base;
    s_data        = '0;
    s_valid       = 1'b0;
    reg_req       = 1'b0;
    reg_we        = 1'b0;
    reg_addr      = '0;
    reg_wdata     = '0;
    arst_n        = 1'b0;
    rnd_state     = 32'h8873_a493;
    rand_ready    = 1'b0;
    hold_ready    = 1'b1;
    cfg_gain      = stream_pkg::GainReset;
    cfg_offset    = '0;
    acc_cnt       = 0;
    out_cnt       = 0;
    sat_exp       = 0;
    mismatch_errs = 0;
    other_errs    = 0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    // Reset values, then write and read back
    reg_check(stream_pkg::ADDR_GAIN, 16'h0010);  // Unity gain
    reg_check(stream_pkg::ADDR_OFFSET, 16'h0000);
    reg_check(stream_pkg::ADDR_CTRL, 16'h0000);
    reg_check(stream_pkg::ADDR_SATCNT, 16'h0000);
    reg_write(stream_pkg::ADDR_GAIN, 16'h0024);
    reg_write(stream_pkg::ADDR_OFFSET, 16'hfff3);
    reg_write(stream_pkg::ADDR_CTRL, 16'h0001);
    reg_check(stream_pkg::ADDR_GAIN, 16'h0024);
    reg_check(stream_pkg::ADDR_OFFSET, 16'hfff3);
    reg_check(stream_pkg::ADDR_CTRL, 16'h0001);

    // Unity gain, then a random gain and offset, sink ready at random
    reg_write(stream_pkg::ADDR_GAIN, 16'h0010);
    reg_write(stream_pkg::ADDR_OFFSET, 16'h0000);
    rand_ready = 1'b1;
    send(24, 1'b0);
    drain();
    rnd_state = lcg_next(rnd_state);
    reg_write(stream_pkg::ADDR_GAIN, {8'h00, rnd_state[23:16]});
    reg_write(stream_pkg::ADDR_OFFSET, {{4{rnd_state[11]}}, rnd_state[11:0]});
    send(32, 1'b0);
    drain();

    // Clipping and the clip counter
    reg_write(stream_pkg::ADDR_GAIN, 16'h00ff);
    reg_write(stream_pkg::ADDR_OFFSET, 16'h0000);
    reg_write(stream_pkg::ADDR_SATCNT, 16'h0000);
    sat_exp = 0;
    send(12, 1'b1);
    drain();
    reg_check(stream_pkg::ADDR_SATCNT, 16'(sat_exp));
    reg_write(stream_pkg::ADDR_SATCNT, 16'h0000);
    reg_check(stream_pkg::ADDR_SATCNT, 16'h0000);

    // Back-pressure fills both FIFOs and the stage register
    reg_write(stream_pkg::ADDR_GAIN, 16'h0010);
    rand_ready = 1'b0;
    hold_ready = 1'b0;
    repeat (2) @(negedge clk);
    base    = acc_cnt;
    last    = acc_cnt;
    s_data  = next_sample(1'b0);
    s_valid = 1'b1;
    repeat (3 * (InDepth + OutDepth)) begin
      @(negedge clk);
      if (acc_cnt > last) begin
        last   = acc_cnt;
        s_data = next_sample(1'b0);
      end
    end
    if (acc_cnt - base != InDepth + OutDepth + 1 || s_ready) begin
      mismatch_errs++;
      $display("MISMATCH at %0t: %0d samples accepted under back-pressure, expected %0d",
               $time, acc_cnt - base, InDepth + OutDepth + 1);
    end
    hold_ready = 1'b1;
    wait_accept(acc_cnt + 1);
    s_valid = 1'b0;
    drain();

    // Disabled stage holds the stream in the input FIFO
    reg_write(stream_pkg::ADDR_CTRL, 16'h0000);
    base     = acc_cnt;
    out_base = out_cnt;
    send(InDepth, 1'b0);
    s_data  = next_sample(1'b0);
    s_valid = 1'b1;
    repeat (3 * InDepth) @(negedge clk);
    if (acc_cnt != base + InDepth || out_cnt != out_base || s_ready) begin
      mismatch_errs++;
      $display("MISMATCH at %0t: stream moved while disabled", $time);
    end
    reg_write(stream_pkg::ADDR_CTRL, 16'h0001);
    wait_accept(base + InDepth + 1);
    s_valid = 1'b0;
    drain();

    // Single sample through empty FIFOs
    out_base = out_cnt;
    send(1, 1'b0);
    if (!m_valid || out_cnt != out_base) begin
      mismatch_errs++;
      $display("MISMATCH at %0t: output not valid one cycle after the input", $time);
    end
    @(negedge clk);
    if (out_cnt != out_base + 1) begin
      mismatch_errs++;
      $display("MISMATCH at %0t: fall-through output not taken on time", $time);
    end

    $display("Errors: %0d mismatch, %0d protocol or timeout, %0d assertion",
             mismatch_errs, other_errs, dut.u_chk.fail_cnt);
    if (mismatch_errs + other_errs + dut.u_chk.fail_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
src/stream_pkg.sv
src/fifo.sv
src/gain_stage.sv
src/scaler_regs.sv
src/stream_scaler_top.sv
bench/stream_scaler_chk.sv
bench/tb_stream_scaler.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the stream scaler testbench with Verilator, runs it and checks the log
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --assert -Wno-fatal -f sources.f \
  --top-module tb_stream_scaler -o sim_stream_scaler

./obj_dir/sim_stream_scaler +verilator+error+limit+1000 | tee sim.log

if grep -qx "Testbench passed" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi
